// File: Bender.yml
package:
  name: pce

sources:
  - pce_pkg.sv
  - pce_fifo.sv
  - pce_endian.sv
  - pce_ctrl.sv
  - pce_top.sv
  - target: simulation
    files:
      - pce_assertions.sv
      - tb_pce.sv

// File: compile.f
pce_pkg.sv
pce_fifo.sv
pce_endian.sv
pce_ctrl.sv
pce_top.sv
pce_assertions.sv
tb_pce.sv

// File: pce_assertions.sv
/* Concurrent checks on packet stability, completion and request FIFO fill */
`timescale 1ns/1ns
`default_nettype none

module pce_assertions (
  input wire         clk_i,
  input wire         reset_i,
  input wire         req_v_i,
  input wire         req_ready_o,
  input wire         complete_o,
  input wire         l15_req_v_o,
  input wire         l15_req_ready_i,
  input wire         l15_rqtype_o,
  input wire         l15_nc_o,
  input wire [31:0]  l15_addr_o,
  input wire [1:0]   l15_size_o,
  input wire [63:0]  l15_data_o,
  input wire         tag_pkt_v_o,
  input wire         tag_yumi_i,
  input wire [1:0]   tag_op_o,
  input wire [5:0]   tag_index_o,
  input wire [1:0]   tag_way_o,
  input wire [21:0]  tag_tag_o,
  input wire [1:0]   tag_state_o,
  input wire         data_pkt_v_o,
  input wire         data_yumi_i,
  input wire         data_op_o,
  input wire [5:0]   data_index_o,
  input wire [1:0]   data_way_o,
  input wire [127:0] data_data_o
);

  int fail_count = 0;
  // Requests accepted and not yet retired
  logic [2:0] queued_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      queued_r <= '0;
    else
      queued_r <= queued_r + 3'(req_v_i && req_ready_o) - 3'(complete_o);
  end

  l15_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    l15_req_v_o && !l15_req_ready_i |=> l15_req_v_o &&
    $stable({l15_rqtype_o, l15_nc_o, l15_addr_o, l15_size_o, l15_data_o}))
  else
  begin
    fail_count++;
    $error("L1.5 request dropped or changed before it was taken");
  end

  tag_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_pkt_v_o && !tag_yumi_i |=> tag_pkt_v_o &&
    $stable({tag_op_o, tag_index_o, tag_way_o, tag_tag_o, tag_state_o}))
  else
  begin
    fail_count++;
    $error("Tag packet dropped or changed before it was taken");
  end

  data_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    data_pkt_v_o && !data_yumi_i |=> data_pkt_v_o &&
    $stable({data_op_o, data_index_o, data_way_o, data_data_o}))
  else
  begin
    fail_count++;
    $error("Data packet dropped or changed before it was taken");
  end

  complete_with_head: assert property (@(posedge clk_i) disable iff (reset_i)
    complete_o |-> queued_r != 0)
  else
  begin
    fail_count++;
    $error("complete_o with no request queued");
  end

  ready_only_full: assert property (@(posedge clk_i) disable iff (reset_i)
    !req_ready_o |-> queued_r == pce_pkg::REQ_DEPTH)
  else
  begin
    fail_count++;
    $error("req_ready_o low while the request FIFO has room");
  end

endmodule

`default_nettype wire

// File: pce_ctrl.sv
/* Engine FSM: init wait, tag clear sweep, L1.5 request issue, return
   handling and invalidation priority */
`timescale 1ns/1ns
`default_nettype none

module pce_ctrl (
  input  wire                                clk_i,
  input  wire                                reset_i,

  input  wire                                req_v_i,
  input  wire pce_pkg::req_type_e            req_type_i,
  input  wire  [pce_pkg::PADDR_W-1:0]        req_addr_i,
  input  wire pce_pkg::size_e                req_size_i,
  input  wire  [pce_pkg::WAY_W-1:0]          req_way_i,
  output logic                               req_yumi_o,

  input  wire                                ret_v_i,
  input  wire pce_pkg::rtntype_e             ret_rtntype_i,
  input  wire                                ret_nc_i,
  input  wire pce_pkg::ret_payload_u         ret_payload_i,
  output logic                               ret_yumi_o,

  input  wire  [pce_pkg::DWORD_W-1:0]        store_data_i,
  input  wire  [pce_pkg::FILL_W-1:0]         uc_fill_i,
  input  wire  [pce_pkg::FILL_W-1:0]         block_fill_i,

  output logic                               l15_req_v_o,
  output pce_pkg::rqtype_e                   l15_rqtype_o,
  output logic                               l15_nc_o,
  output logic [pce_pkg::PADDR_W-1:0]        l15_addr_o,
  output pce_pkg::size_e                     l15_size_o,
  output logic [pce_pkg::DWORD_W-1:0]        l15_data_o,
  input  wire                                l15_req_ready_i,

  output logic                               tag_pkt_v_o,
  output pce_pkg::tag_op_e                   tag_op_o,
  output logic [pce_pkg::INDEX_W-1:0]        tag_index_o,
  output logic [pce_pkg::WAY_W-1:0]          tag_way_o,
  output logic [pce_pkg::TAG_W-1:0]          tag_tag_o,
  output pce_pkg::coh_state_e                tag_state_o,
  input  wire                                tag_yumi_i,

  output logic                               data_pkt_v_o,
  output pce_pkg::data_op_e                  data_op_o,
  output logic [pce_pkg::INDEX_W-1:0]        data_index_o,
  output logic [pce_pkg::WAY_W-1:0]          data_way_o,
  output logic [pce_pkg::FILL_W-1:0]         data_data_o,
  input  wire                                data_yumi_i,

  output logic                               complete_o
);

  enum logic [2:0] {wait_init, clear, ready, store_wait, uc_read_wait, read_wait}
    state_r, state_n;

  logic [pce_pkg::INDEX_W-1:0] index_r;
  logic index_up;
  logic index_done;
  logic [pce_pkg::INDEX_W-1:0] req_index;
  logic inval_v;
  logic load_ret_nc;
  logic load_ret_block;

  assign index_done = (index_r == pce_pkg::SETS-1);
  assign req_index = req_addr_i[pce_pkg::BLOCK_OFFSET_W +: pce_pkg::INDEX_W];

  // Invalidations only count once the clear sweep is over
  assign inval_v = ret_v_i & (ret_rtntype_i == pce_pkg::inval_ret)
                   & (state_r != wait_init) & (state_r != clear);
  assign load_ret_nc = ret_v_i & (ret_rtntype_i == pce_pkg::load_ret) & ret_nc_i;
  assign load_ret_block = ret_v_i & (ret_rtntype_i == pce_pkg::load_ret) & ~ret_nc_i;

  assign req_yumi_o = complete_o;

  always_comb
  begin
    state_n = state_r;
    index_up = 1'b0;
    complete_o = 1'b0;
    ret_yumi_o = 1'b0;

    l15_req_v_o = 1'b0;
    l15_rqtype_o = pce_pkg::load_req;
    l15_nc_o = 1'b0;
    l15_addr_o = req_addr_i;
    l15_size_o = req_size_i;
    l15_data_o = store_data_i;

    tag_pkt_v_o = 1'b0;
    tag_op_o = pce_pkg::set_clear;
    tag_index_o = index_r;
    tag_way_o = '0;
    tag_tag_o = '0;
    tag_state_o = pce_pkg::COH_I;

    data_pkt_v_o = 1'b0;
    data_op_o = pce_pkg::write_block;
    data_index_o = req_index;
    data_way_o = req_way_i;
    data_data_o = block_fill_i;

    case (state_r)
      wait_init:
      begin
        ret_yumi_o = ret_v_i & (ret_rtntype_i == pce_pkg::int_ret);
        if (ret_yumi_o)
          state_n = clear;
      end
      clear:
      begin
        tag_pkt_v_o = 1'b1;
        index_up = tag_yumi_i;
        if (index_up & index_done)
          state_n = ready;
      end
      ready:
      begin
        l15_req_v_o = req_v_i;
        case (req_type_i)
          pce_pkg::uc_store:
          begin
            l15_rqtype_o = pce_pkg::store_req;
            l15_nc_o = 1'b1;
          end
          pce_pkg::uc_load:
            l15_nc_o = 1'b1;
          default:
            l15_addr_o = {req_addr_i[pce_pkg::PADDR_W-1:pce_pkg::BLOCK_OFFSET_W],
                          {pce_pkg::BLOCK_OFFSET_W{1'b0}}};
        endcase
        if (l15_req_v_o & l15_req_ready_i)
        begin
          if (req_type_i == pce_pkg::uc_store)
            state_n = store_wait;
          else if (req_type_i == pce_pkg::uc_load)
            state_n = uc_read_wait;
          else
            state_n = read_wait;
        end
      end
      store_wait:
      begin
        ret_yumi_o = ret_v_i & (ret_rtntype_i == pce_pkg::st_ack);
        complete_o = ret_yumi_o;
        if (complete_o)
          state_n = ready;
      end
      uc_read_wait:
      begin
        data_op_o = pce_pkg::uncached;
        data_data_o = uc_fill_i;
        data_pkt_v_o = load_ret_nc;
        ret_yumi_o = data_pkt_v_o & data_yumi_i;
        complete_o = ret_yumi_o;
        if (complete_o)
          state_n = ready;
      end
      read_wait:
      begin
        data_pkt_v_o = load_ret_block;
        tag_pkt_v_o = load_ret_block;
        tag_op_o = pce_pkg::set_tag;
        tag_index_o = req_index;
        tag_way_o = req_way_i;
        tag_tag_o = req_addr_i[pce_pkg::BLOCK_OFFSET_W+pce_pkg::INDEX_W +: pce_pkg::TAG_W];
        tag_state_o = pce_pkg::COH_M;
        // Data and tag are taken together
        ret_yumi_o = load_ret_block & data_yumi_i & tag_yumi_i;
        complete_o = ret_yumi_o;
        if (complete_o)
          state_n = ready;
      end
      default:
        state_n = wait_init;
    endcase

    // Invalidation at the return head wins the tag port
    if (inval_v)
    begin
      tag_pkt_v_o = 1'b1;
      tag_op_o = pce_pkg::set_state;
      tag_index_o = ret_payload_i.inval.inval_index;
      tag_way_o = ret_payload_i.inval.inval_way;
      tag_tag_o = '0;
      tag_state_o = pce_pkg::COH_I;
      data_pkt_v_o = 1'b0;
      ret_yumi_o = tag_yumi_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= wait_init;
      index_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (index_up)
        index_r <= index_r + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: pce_endian.sv
/* Byte-order swap and size replication between the little-endian cache
   and the big-endian L1.5, for store data and returned fills */
`timescale 1ns/1ns
`default_nettype none

module pce_endian (
  input  wire pce_pkg::size_e               size_i,
  input  wire  [pce_pkg::PADDR_W-1:0]       addr_i,
  input  wire  [pce_pkg::DWORD_W-1:0]       store_data_i,
  input  wire pce_pkg::ret_payload_u        payload_i,
  output logic [pce_pkg::DWORD_W-1:0]       store_data_o,
  output logic [pce_pkg::FILL_W-1:0]        uc_fill_o,
  output logic [pce_pkg::FILL_W-1:0]        block_fill_o
);

  logic [pce_pkg::DWORD_W-1:0] uc_dword;
  logic [pce_pkg::DWORD_W-1:0] data_1_swap;
  logic [pce_pkg::DWORD_W-1:0] data_0_swap;

  // Reverse the 8 bytes of a doubleword
  function automatic logic [pce_pkg::DWORD_W-1:0] bswap(
    input logic [pce_pkg::DWORD_W-1:0] d
  );
    logic [pce_pkg::DWORD_W-1:0] r;
    for (int i = 0; i < 8; i++)
      r[8*i +: 8] = d[8*(7-i) +: 8];
    return r;
  endfunction

  // Store data, low bytes reversed within the access size and replicated
  always_comb
  begin
    case (size_i)
      pce_pkg::size_1b:
        store_data_o = {8{store_data_i[7:0]}};
      pce_pkg::size_2b:
        store_data_o = {4{store_data_i[7:0], store_data_i[15:8]}};
      pce_pkg::size_4b:
        store_data_o = {2{store_data_i[7:0], store_data_i[15:8],
                          store_data_i[23:16], store_data_i[31:24]}};
      default:
        store_data_o = bswap(store_data_i);
    endcase
  end

  assign data_1_swap = bswap(payload_i.data.data_1);
  assign data_0_swap = bswap(payload_i.data.data_0);

  // Address bit 3 picks the doubleword of an uncached return
  assign uc_dword = addr_i[3] ? data_1_swap : data_0_swap;

  always_comb
  begin
    case (size_i)
      pce_pkg::size_1b: uc_fill_o = {16{uc_dword[7:0]}};
      pce_pkg::size_2b: uc_fill_o = {8{uc_dword[15:0]}};
      pce_pkg::size_4b: uc_fill_o = {4{uc_dword[31:0]}};
      default:          uc_fill_o = {2{uc_dword}};
    endcase
  end

  assign block_fill_o = {data_1_swap, data_0_swap};

endmodule

`default_nettype wire

// File: pce_fifo.sv
/* Small circular FIFO, valid/ready on the input, valid/yumi on the output */
`timescale 1ns/1ns
`default_nettype none

module pce_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  wire              clk_i,
  input  wire              reset_i,
  input  wire  [WIDTH-1:0] data_i,
  input  wire              v_i,
  output logic             ready_o,
  output logic [WIDTH-1:0] data_o,
  output logic             v_o,
  input  wire              yumi_i
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] rd_ptr_r;
  logic [$clog2(DEPTH)-1:0] wr_ptr_r;
  logic [$clog2(DEPTH+1)-1:0] count_r;
  logic enq;

  assign ready_o = (count_r != DEPTH);
  assign v_o = (count_r != 0);
  assign data_o = mem[rd_ptr_r];
  assign enq = v_i & ready_o;

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem[wr_ptr_r] <= data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= (wr_ptr_r == DEPTH-1) ? '0 : wr_ptr_r + 1'b1;
      if (yumi_i)
        rd_ptr_r <= (rd_ptr_r == DEPTH-1) ? '0 : rd_ptr_r + 1'b1;
      case ({enq, yumi_i})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: pce_pkg.sv
/* Shared widths, request/return/memory enums and the L1.5 return payload union
   for the data-cache engine */
`default_nettype none

package pce_pkg;

  localparam int PADDR_W = 32;
  localparam int DWORD_W = 64;
  localparam int FILL_W = 128;
  localparam int BLOCK_OFFSET_W = 4;
  localparam int INDEX_W = 6;
  localparam int SETS = 64;
  localparam int WAY_W = 2;
  localparam int TAG_W = 22;

  localparam int REQ_DEPTH = 2;
  localparam int RET_DEPTH = 4;

  // Cache request kinds
  typedef enum logic [1:0] {
    miss_load,
    uc_load,
    uc_store
  } req_type_e;

  // Access size in bytes, same code toward the L1.5
  typedef enum logic [1:0] {
    size_1b,
    size_2b,
    size_4b,
    size_8b
  } size_e;

  typedef enum logic {
    load_req,
    store_req
  } rqtype_e;

  typedef enum logic [1:0] {
    int_ret,
    load_ret,
    st_ack,
    inval_ret
  } rtntype_e;

  typedef enum logic [1:0] {
    set_clear,
    set_tag,
    set_state
  } tag_op_e;

  typedef enum logic {
    write_block,
    uncached
  } data_op_e;

  typedef enum logic [1:0] {
    COH_I,
    COH_S,
    COH_M
  } coh_state_e;

  // Return payload is either two data doublewords or invalidation fields
  typedef union packed {
    struct packed {
      logic [DWORD_W-1:0] data_1;
      logic [DWORD_W-1:0] data_0;
    } data;
    struct packed {
      logic [FILL_W-WAY_W-INDEX_W-1:0] padding;
      logic [WAY_W-1:0] inval_way;
      logic [INDEX_W-1:0] inval_index;
    } inval;
  } ret_payload_u;

  // FIFO entry widths
  localparam int RET_W = $bits(rtntype_e) + 1 + $bits(ret_payload_u);
  localparam int REQ_W = $bits(req_type_e) + $bits(size_e) + PADDR_W + DWORD_W + WAY_W;

endpackage

`default_nettype wire

// File: pce_top.sv
/* Engine top: request and return FIFOs, endian converter and controller */
`timescale 1ns/1ns
`default_nettype none

module pce_top (
  input  wire                                clk_i,
  input  wire                                reset_i,

  input  wire                                req_v_i,
  input  wire pce_pkg::req_type_e            req_type_i,
  input  wire pce_pkg::size_e                req_size_i,
  input  wire  [pce_pkg::PADDR_W-1:0]        req_addr_i,
  input  wire  [pce_pkg::DWORD_W-1:0]        req_data_i,
  input  wire  [pce_pkg::WAY_W-1:0]          req_way_i,
  output logic                               req_ready_o,

  input  wire                                ret_v_i,
  input  wire pce_pkg::rtntype_e             ret_rtntype_i,
  input  wire                                ret_nc_i,
  input  wire pce_pkg::ret_payload_u         ret_payload_i,
  output logic                               ret_ready_o,

  output logic                               l15_req_v_o,
  output pce_pkg::rqtype_e                   l15_rqtype_o,
  output logic                               l15_nc_o,
  output logic [pce_pkg::PADDR_W-1:0]        l15_addr_o,
  output pce_pkg::size_e                     l15_size_o,
  output logic [pce_pkg::DWORD_W-1:0]        l15_data_o,
  input  wire                                l15_req_ready_i,

  output logic                               tag_pkt_v_o,
  output pce_pkg::tag_op_e                   tag_op_o,
  output logic [pce_pkg::INDEX_W-1:0]        tag_index_o,
  output logic [pce_pkg::WAY_W-1:0]          tag_way_o,
  output logic [pce_pkg::TAG_W-1:0]          tag_tag_o,
  output pce_pkg::coh_state_e                tag_state_o,
  input  wire                                tag_yumi_i,

  output logic                               data_pkt_v_o,
  output pce_pkg::data_op_e                  data_op_o,
  output logic [pce_pkg::INDEX_W-1:0]        data_index_o,
  output logic [pce_pkg::WAY_W-1:0]          data_way_o,
  output logic [pce_pkg::FILL_W-1:0]         data_data_o,
  input  wire                                data_yumi_i,

  output logic                               complete_o
);

  logic [pce_pkg::REQ_W-1:0] req_head;
  logic req_head_v;
  logic req_yumi;
  logic [1:0] head_type;
  logic [1:0] head_size;
  logic [pce_pkg::PADDR_W-1:0] head_addr;
  logic [pce_pkg::DWORD_W-1:0] head_data;
  logic [pce_pkg::WAY_W-1:0] head_way;

  logic [pce_pkg::RET_W-1:0] ret_head;
  logic ret_head_v;
  logic ret_yumi;
  logic [1:0] ret_head_type;
  logic ret_head_nc;
  pce_pkg::ret_payload_u ret_head_payload;

  logic [pce_pkg::DWORD_W-1:0] store_data;
  logic [pce_pkg::FILL_W-1:0] uc_fill;
  logic [pce_pkg::FILL_W-1:0] block_fill;

  assign {head_type, head_size, head_addr, head_data, head_way} = req_head;
  assign {ret_head_type, ret_head_nc, ret_head_payload} = ret_head;

  pce_fifo #(
    .WIDTH(pce_pkg::REQ_W),
    .DEPTH(pce_pkg::REQ_DEPTH)
  ) req_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .data_i({req_type_i, req_size_i, req_addr_i, req_data_i, req_way_i}),
    .v_i(req_v_i),
    .ready_o(req_ready_o),
    .data_o(req_head),
    .v_o(req_head_v),
    .yumi_i(req_yumi)
  );

  pce_fifo #(
    .WIDTH(pce_pkg::RET_W),
    .DEPTH(pce_pkg::RET_DEPTH)
  ) ret_fifo (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .data_i({ret_rtntype_i, ret_nc_i, ret_payload_i}),
    .v_i(ret_v_i),
    .ready_o(ret_ready_o),
    .data_o(ret_head),
    .v_o(ret_head_v),
    .yumi_i(ret_yumi)
  );

  pce_endian endian (
    .size_i(pce_pkg::size_e'(head_size)),
    .addr_i(head_addr),
    .store_data_i(head_data),
    .payload_i(ret_head_payload),
    .store_data_o(store_data),
    .uc_fill_o(uc_fill),
    .block_fill_o(block_fill)
  );

  pce_ctrl ctrl (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .req_v_i(req_head_v),
    .req_type_i(pce_pkg::req_type_e'(head_type)),
    .req_addr_i(head_addr),
    .req_size_i(pce_pkg::size_e'(head_size)),
    .req_way_i(head_way),
    .req_yumi_o(req_yumi),
    .ret_v_i(ret_head_v),
    .ret_rtntype_i(pce_pkg::rtntype_e'(ret_head_type)),
    .ret_nc_i(ret_head_nc),
    .ret_payload_i(ret_head_payload),
    .ret_yumi_o(ret_yumi),
    .store_data_i(store_data),
    .uc_fill_i(uc_fill),
    .block_fill_i(block_fill),
    .l15_req_v_o(l15_req_v_o),
    .l15_rqtype_o(l15_rqtype_o),
    .l15_nc_o(l15_nc_o),
    .l15_addr_o(l15_addr_o),
    .l15_size_o(l15_size_o),
    .l15_data_o(l15_data_o),
    .l15_req_ready_i(l15_req_ready_i),
    .tag_pkt_v_o(tag_pkt_v_o),
    .tag_op_o(tag_op_o),
    .tag_index_o(tag_index_o),
    .tag_way_o(tag_way_o),
    .tag_tag_o(tag_tag_o),
    .tag_state_o(tag_state_o),
    .tag_yumi_i(tag_yumi_i),
    .data_pkt_v_o(data_pkt_v_o),
    .data_op_o(data_op_o),
    .data_index_o(data_index_o),
    .data_way_o(data_way_o),
    .data_data_o(data_data_o),
    .data_yumi_i(data_yumi_i),
    .complete_o(complete_o)
  );

endmodule

`default_nettype wire

// File: tb_pce.sv
/* Testbench for the data-cache engine with L1.5 and memory models,
   a watchdog and the closing report */
`timescale 1ns/1ns
`default_nettype none

module tb_pce;

  localparam int N_REQ = 24;
  localparam int CLK_NS = 4;
  localparam int TIMEOUT_NS = (64 + 40 * N_REQ) * CLK_NS * 4;

  logic clk_i;
  logic reset_i;
  logic req_v_i;
  pce_pkg::req_type_e req_type_i;
  pce_pkg::size_e req_size_i;
  logic [pce_pkg::PADDR_W-1:0] req_addr_i;
  logic [pce_pkg::DWORD_W-1:0] req_data_i;
  logic [pce_pkg::WAY_W-1:0] req_way_i;
  logic req_ready_o;
  logic ret_v_i;
  pce_pkg::rtntype_e ret_rtntype_i;
  logic ret_nc_i;
  pce_pkg::ret_payload_u ret_payload_i;
  logic ret_ready_o;
  logic l15_req_v_o;
  pce_pkg::rqtype_e l15_rqtype_o;
  logic l15_nc_o;
  logic [pce_pkg::PADDR_W-1:0] l15_addr_o;
  pce_pkg::size_e l15_size_o;
  logic [pce_pkg::DWORD_W-1:0] l15_data_o;
  logic l15_req_ready_i;
  logic tag_pkt_v_o;
  pce_pkg::tag_op_e tag_op_o;
  logic [pce_pkg::INDEX_W-1:0] tag_index_o;
  logic [pce_pkg::WAY_W-1:0] tag_way_o;
  logic [pce_pkg::TAG_W-1:0] tag_tag_o;
  pce_pkg::coh_state_e tag_state_o;
  logic tag_yumi_i;
  logic data_pkt_v_o;
  pce_pkg::data_op_e data_op_o;
  logic [pce_pkg::INDEX_W-1:0] data_index_o;
  logic [pce_pkg::WAY_W-1:0] data_way_o;
  logic [pce_pkg::FILL_W-1:0] data_data_o;
  logic data_yumi_i;
  logic complete_o;

  // Pre-generated stimulus, one entry per request
  pce_pkg::req_type_e r_type [N_REQ];
  pce_pkg::size_e r_size [N_REQ];
  logic [31:0] r_addr [N_REQ];
  logic [63:0] r_data [N_REQ];
  logic [1:0] r_way [N_REQ];
  logic [127:0] r_payload [N_REQ];
  int r_delay [N_REQ];
  // Bit 8 asks for an invalidation, low bits are way and index
  logic [8:0] inval_pre [N_REQ];
  logic [8:0] inval_mid [N_REQ];

  logic [pce_pkg::RET_W-1:0] ret_q [$];
  logic [7:0] inval_q [$];
  integer seed;
  int error_count = 0;
  int sweep_count = 0;
  int done_count = 0;
  int resp_count = 0;
  bit init_sent = 1'b0;

  pce_top pce_top_inst (.*);

  bind pce_top pce_assertions checks (.*);

  // Little-endian data to the big-endian image, low size-bytes reversed and repeated
  function automatic logic [63:0] store_image(input logic [63:0] d, input logic [1:0] size);
    logic [63:0] r;
    int n;
    n = 1 << size;
    for (int i = 0; i < 8; i++)
      r[8*i +: 8] = d[8*(n-1-(i % n)) +: 8];
    return r;
  endfunction

  function automatic logic [127:0] uc_fill_expect(input logic [127:0] p,
                                                  input logic [31:0] addr,
                                                  input logic [1:0] size);
    logic [63:0] w;
    logic [127:0] r;
    int n;
    w = store_image(addr[3] ? p[127:64] : p[63:0], 2'd3);
    n = 1 << size;
    for (int i = 0; i < 16; i++)
      r[8*i +: 8] = w[8*(i % n) +: 8];
    return r;
  endfunction

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (act === exp)
    else
    begin
      error_count++;
      $display("ERROR %0t ns %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("%0t ns: %s", $time, msg);
  endtask

  task automatic push_inval(input logic [7:0] way_index);
    ret_q.push_back({pce_pkg::inval_ret, 1'b0, {(pce_pkg::FILL_W-8){1'b0}}, way_index});
    inval_q.push_back(way_index);
  endtask

  task automatic send_request(input int i);
    bit taken;
    @(posedge clk_i);
    #1;
    req_v_i = 1'b1;
    req_type_i = r_type[i];
    req_size_i = r_size[i];
    req_addr_i = r_addr[i];
    req_data_i = r_data[i];
    req_way_i = r_way[i];
    do
    begin
      @(negedge clk_i);
      taken = req_ready_o;
      @(posedge clk_i);
      #1;
    end while (!taken);
    req_v_i = 1'b0;
  endtask

  task automatic check_tag();
    int h;
    h = done_count;
    case (tag_op_o)
      pce_pkg::set_clear:
        if (tag_yumi_i)
        begin
          if (sweep_count >= pce_pkg::SETS)
            report_failure("Clear packet after the sweep had ended");
          check_value("tag_index_o", sweep_count, tag_index_o);
          sweep_count++;
        end
      pce_pkg::set_state:
        if (inval_q.size() == 0)
          report_failure("Invalidation packet with no invalidation pending");
        else
        begin
          check_value("tag_index_o", inval_q[0][5:0], tag_index_o);
          check_value("tag_way_o", inval_q[0][7:6], tag_way_o);
          check_value("tag_state_o", pce_pkg::COH_I, tag_state_o);
          if (tag_yumi_i)
            void'(inval_q.pop_front());
        end
      default:
        if (h >= N_REQ || r_type[h] != pce_pkg::miss_load)
          report_failure("Tag write with no miss at the request head");
        else
        begin
          check_value("tag_op_o", pce_pkg::set_tag, tag_op_o);
          check_value("tag_index_o", r_addr[h][9:4], tag_index_o);
          check_value("tag_way_o", r_way[h], tag_way_o);
          check_value("tag_tag_o", r_addr[h][31:10], tag_tag_o);
          check_value("tag_state_o", pce_pkg::COH_M, tag_state_o);
        end
    endcase
  endtask

  task automatic check_data();
    int h;
    h = done_count;
    if (h >= N_REQ || resp_count <= h || r_type[h] == pce_pkg::uc_store)
      report_failure("Data packet with no load return outstanding");
    else if (r_type[h] == pce_pkg::uc_load)
    begin
      check_value("data_op_o", pce_pkg::uncached, data_op_o);
      check_value("data_data_o", uc_fill_expect(r_payload[h], r_addr[h], r_size[h]),
                  data_data_o);
    end
    else
    begin
      check_value("data_op_o", pce_pkg::write_block, data_op_o);
      check_value("data_index_o", r_addr[h][9:4], data_index_o);
      check_value("data_way_o", r_way[h], data_way_o);
      check_value("data_data_o", {store_image(r_payload[h][127:64], 2'd3),
                                  store_image(r_payload[h][63:0], 2'd3)}, data_data_o);
    end
  endtask

  task automatic check_complete();
    int h;
    h = done_count;
    if (h >= N_REQ || resp_count <= h)
      report_failure("complete_o with no return for the request at the head");
    else if (r_type[h] == pce_pkg::uc_load && !(data_pkt_v_o && data_yumi_i))
      report_failure("Uncached load completed without its data packet being taken");
    else if (r_type[h] == pce_pkg::miss_load && !(data_pkt_v_o && data_yumi_i &&
             tag_pkt_v_o && tag_yumi_i && tag_op_o == pce_pkg::set_tag))
      report_failure("Miss completed without both data and tag packets taken");
    done_count++;
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  // Memory and L1.5 back-pressure
  initial
  begin
    l15_req_ready_i = 1'b0;
    tag_yumi_i = 1'b0;
    data_yumi_i = 1'b0;
    forever
    begin
      @(posedge clk_i);
      #1;
      l15_req_ready_i = ($random(seed) & 3) != 0;
      tag_yumi_i = ($random(seed) & 3) != 0;
      data_yumi_i = ($random(seed) & 3) != 0;
    end
  end

  // Return port driver, fed from ret_q
  initial
  begin
    bit taken;
    ret_v_i = 1'b0;
    ret_rtntype_i = pce_pkg::int_ret;
    ret_nc_i = 1'b0;
    ret_payload_i = '0;
    forever
    begin
      @(negedge clk_i);
      taken = ret_v_i && ret_ready_o;
      @(posedge clk_i);
      #1;
      if (taken)
        void'(ret_q.pop_front());
      ret_v_i = (ret_q.size() != 0);
      if (ret_v_i)
      begin
        ret_rtntype_i = pce_pkg::rtntype_e'(ret_q[0][pce_pkg::RET_W-1 -: 2]);
        ret_nc_i = ret_q[0][pce_pkg::FILL_W];
        ret_payload_i = ret_q[0][pce_pkg::FILL_W-1:0];
      end
    end
  end

  // L1.5 model, one request in flight
  initial
  begin
    int idx;
    forever
    begin
      @(negedge clk_i);
      if (!reset_i && l15_req_v_o && l15_req_ready_i)
      begin
        idx = done_count;
        check_value("l15_rqtype_o", (r_type[idx] == pce_pkg::uc_store) ?
                    pce_pkg::store_req : pce_pkg::load_req, l15_rqtype_o);
        check_value("l15_nc_o", r_type[idx] != pce_pkg::miss_load, l15_nc_o);
        check_value("l15_addr_o", (r_type[idx] == pce_pkg::miss_load) ?
                    {r_addr[idx][31:4], 4'h0} : r_addr[idx], l15_addr_o);
        check_value("l15_size_o", r_size[idx], l15_size_o);
        if (r_type[idx] == pce_pkg::uc_store)
          check_value("l15_data_o", store_image(r_data[idx], r_size[idx]), l15_data_o);
        repeat (r_delay[idx] + 1) @(negedge clk_i);
        if (inval_mid[idx][8])
          push_inval(inval_mid[idx][7:0]);
        if (r_type[idx] == pce_pkg::uc_store)
          ret_q.push_back({pce_pkg::st_ack, 1'b1, r_payload[idx]});
        else
          ret_q.push_back({pce_pkg::load_ret, r_type[idx] == pce_pkg::uc_load,
                           r_payload[idx]});
        resp_count++;
      end
    end
  end

  always @(negedge clk_i)
  begin
    if (!reset_i)
    begin
      if (!init_sent && (tag_pkt_v_o || l15_req_v_o || complete_o))
        report_failure("Engine output active before the init return");
      if (tag_pkt_v_o)
        check_tag();
      if (data_pkt_v_o)
        check_data();
      if (complete_o)
        check_complete();
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, %0d of %0d requests completed",
             TIMEOUT_NS, done_count, N_REQ);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    seed = 98;
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_type_i = pce_pkg::miss_load;
    req_size_i = pce_pkg::size_1b;
    req_addr_i = '0;
    req_data_i = '0;
    req_way_i = '0;
    for (int i = 0; i < N_REQ; i++)
    begin
      r_type[i] = pce_pkg::req_type_e'(i % 3);
      r_size[i] = pce_pkg::size_e'((i / 3) % 4);
      r_addr[i] = $random(seed);
      r_data[i] = {$random(seed), $random(seed)};
      r_way[i] = $random(seed);
      r_delay[i] = $random(seed) & 7;
      inval_pre[i] = $random(seed);
      inval_mid[i] = $random(seed);
      if (r_type[i] == pce_pkg::uc_load)
        r_payload[i] = {store_image(r_data[i], r_size[i]), store_image(~r_data[i], r_size[i])};
      else
        r_payload[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    end
    repeat (4) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    // Quiet period before the init return
    repeat (6) @(negedge clk_i);
    ret_q.push_back({pce_pkg::int_ret, 1'b0, {pce_pkg::FILL_W{1'b0}}});
    init_sent = 1'b1;
    while (sweep_count < pce_pkg::SETS)
      @(posedge clk_i);
    for (int i = 0; i < N_REQ; i++)
    begin
      if (inval_pre[i][8])
      begin
        @(negedge clk_i);
        push_inval(inval_pre[i][7:0]);
      end
      send_request(i);
    end
    while (done_count < N_REQ || inval_q.size() != 0)
      @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    if (sweep_count != pce_pkg::SETS)
      report_failure("Clear sweep did not cover every set exactly once");
    $display("Errors: %0d testbench checks, %0d assertions",
             error_count, pce_top_inst.checks.fail_count);
    if (error_count == 0 && pce_top_inst.checks.fail_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
